//--- b64_enc.f
logic/b64_pkg.sv
logic/b64_csr.sv
logic/b64_group_packer.sv
logic/b64_sextet_sequencer.sv
logic/b64_alphabet_map.sv
logic/b64_enc_top.sv
testbench/b64_enc_tb.sv

//--- Bender.yml
package:
  name: b64_enc

sources:
  - logic/b64_pkg.sv
  - logic/b64_csr.sv
  - logic/b64_group_packer.sv
  - logic/b64_sextet_sequencer.sv
  - logic/b64_alphabet_map.sv
  - logic/b64_enc_top.sv
  - target: simulation
    files:
      - testbench/b64_enc_tb.sv

//--- testbench/b64_enc_golden.txt
# W offset value, R offset expected: register write and read, all hex
# B byte last, E char last: input byte and expected character; M ends a message
R 0 00000002
B 4d 0
B 61 0
B 6e 0
B 79 1
E 54 0
E 57 0
E 46 0
E 75 0
E 65 0
E 51 0
E 3d 0
E 3d 1
M
R 4 00000004
R 8 00000008
R c 00000000
W 4 00000000
B 4d 1
E 54 0
E 51 0
E 3d 0
E 3d 1
M
W 0 00000000
B 4d 0
B 61 1
E 54 0
E 57 0
E 45 1
M
W 0 00000002
B fb 0
B ff 1
E 2b 0
E 2f 0
E 38 0
E 3d 1
M
W 0 00000003
B fb 0
B ff 1
E 2d 0
E 5f 0
E 38 0
E 3d 1
M
R 0 00000003
R 4 00000007
R 8 0000000f
R c 00000000

//--- testbench/b64_enc_tb.sv
// Base64 encoder testbench
// Replays the golden file through the byte stream and the AXI4-Lite port

`timescale 1ns/100ps

module b64_enc_tb;
    localparam int TIMEOUT = 1000;

    logic        clk, rst_n;
    logic        in_valid, in_last, out_ready;
    logic [7:0]  in_data;
    logic        awvalid, wvalid, bready, arvalid, rready;
    logic [3:0]  awaddr, araddr;
    logic [31:0] wdata;
    wire         in_ready, out_valid, out_last, awready, wready, bvalid, arready, rvalid;
    wire  [7:0]  out_data;
    wire  [31:0] rdata;
    wire  [1:0]  bresp, rresp;

    // Message queues filled from B and E lines
    logic [7:0]  byte_q[$];
    logic        blast_q[$];
    logic [7:0]  exp_q[$];
    logic        elast_q[$];

    logic [15:0] drv_lfsr, chk_lfsr;
    int          mismatch_errs, timeout_errs, other_errs, msg_count;
    int          fd, code;
    logic [7:0]  tag, col_a;
    logic [31:0] col_b;
    logic [8*128-1:0] skip_line;

    b64_enc_top #(
        .CSR_ADDR_W (4),
        .COUNT_W    (32)
    ) DUT (
        .clk (clk), .rst_n (rst_n),
        .in_valid (in_valid), .in_ready (in_ready), .in_data (in_data), .in_last (in_last),
        .out_valid (out_valid), .out_ready (out_ready), .out_data (out_data),
        .out_last (out_last),
        .awvalid (awvalid), .awready (awready), .awaddr (awaddr),
        .wvalid (wvalid), .wready (wready), .wdata (wdata),
        .bresp (bresp), .bvalid (bvalid), .bready (bready),
        .arvalid (arvalid), .arready (arready), .araddr (araddr),
        .rvalid (rvalid), .rready (rready), .rdata (rdata), .rresp (rresp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one new bit per step
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic fb;
        fb = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], fb};
    endfunction

    // ------------------------------------------------------------------
    // AXI4-Lite register access
    // ------------------------------------------------------------------
    task automatic write_reg(input logic [3:0] addr, input logic [31:0] data);
        int wait_cnt;
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
        end while (!(awready && wready) && wait_cnt < TIMEOUT);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        if (!(awready && wready)) begin
            $display("Timeout at %0t: write to offset 0x%h not accepted", $time, addr);
            timeout_errs++;
        end
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
        end while (!bvalid && wait_cnt < TIMEOUT);
        if (!bvalid) begin
            $display("Timeout at %0t: no write response for offset 0x%h", $time, addr);
            timeout_errs++;
        end else if (bresp !== 2'b00) begin
            $display("Mismatch at %0t: bresp expected 0 got %0d", $time, bresp);
            mismatch_errs++;
        end
    endtask

    task automatic read_check(input logic [3:0] addr, input logic [31:0] expected);
        int wait_cnt;
        arvalid <= 1'b1;
        araddr  <= addr;
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
        end while (!arready && wait_cnt < TIMEOUT);
        arvalid <= 1'b0;
        wait_cnt = 0;
        do begin
            @(posedge clk);
            wait_cnt++;
        end while (!rvalid && wait_cnt < TIMEOUT);
        if (!rvalid) begin
            $display("Timeout at %0t: read of offset 0x%h never returned data", $time, addr);
            timeout_errs++;
        end else begin
            if (rdata !== expected) begin
                $display("Mismatch at %0t: rdata at offset 0x%h expected %h got %h",
                         $time, addr, expected, rdata);
                mismatch_errs++;
            end
            if (rresp !== 2'b00) begin
                $display("Mismatch at %0t: rresp expected 0 got %0d", $time, rresp);
                mismatch_errs++;
            end
        end
    endtask

    // ------------------------------------------------------------------
    // Stream driver, checker and idle wait
    // ------------------------------------------------------------------
    task automatic drive_bytes();
        int n;
        int wait_cnt;
        for (n = 0; n < byte_q.size(); n++) begin
            // Random one-cycle gap before a byte
            drv_lfsr = lfsr_step(drv_lfsr);
            if (drv_lfsr[0]) begin
                in_valid <= 1'b0;
                @(posedge clk);
            end
            in_valid <= 1'b1;
            in_data  <= byte_q[n];
            in_last  <= blast_q[n];
            wait_cnt = 0;
            do begin
                @(posedge clk);
                wait_cnt++;
            end while (!in_ready && wait_cnt < TIMEOUT);
            if (!in_ready) begin
                $display("Timeout at %0t: input byte %0d never accepted", $time, n);
                timeout_errs++;
            end
        end
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    task automatic check_chars();
        int   n;
        int   wait_cnt;
        logic rdy_a;
        for (n = 0; n < exp_q.size(); n++) begin
            wait_cnt = 0;
            do begin
                // Ready three cycles in four
                chk_lfsr = lfsr_step(chk_lfsr);
                rdy_a    = chk_lfsr[0];
                chk_lfsr = lfsr_step(chk_lfsr);
                out_ready <= rdy_a | chk_lfsr[0];
                @(posedge clk);
                wait_cnt++;
            end while (!(out_valid && out_ready) && wait_cnt < TIMEOUT);
            if (!(out_valid && out_ready)) begin
                $display("Timeout at %0t: output character %0d never arrived", $time, n);
                timeout_errs++;
            end else begin
                if (out_data !== exp_q[n]) begin
                    $display("Mismatch at %0t: out_data expected %h got %h",
                             $time, exp_q[n], out_data);
                    mismatch_errs++;
                end
                if (out_last !== elast_q[n]) begin
                    $display("Mismatch at %0t: out_last expected %b got %b",
                             $time, elast_q[n], out_last);
                    mismatch_errs++;
                end
            end
        end
        out_ready <= 1'b0;
    endtask

    // Idle means no character pending and room for input for four cycles running
    task automatic wait_idle();
        int wait_cnt;
        int quiet;
        wait_cnt = 0;
        quiet    = 0;
        while (quiet < 4 && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
            if (!out_valid && in_ready)
                quiet++;
            else
                quiet = 0;
        end
        if (quiet < 4) begin
            $display("Timeout at %0t: encoder did not go idle after message", $time);
            timeout_errs++;
        end
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------
    initial begin
        rst_n     <= 1'b0;
        in_valid  <= 1'b0;
        in_data   <= 8'h00;
        in_last   <= 1'b0;
        out_ready <= 1'b0;
        awvalid   <= 1'b0;
        awaddr    <= 4'h0;
        wvalid    <= 1'b0;
        wdata     <= 32'h0;
        bready    <= 1'b1;
        arvalid   <= 1'b0;
        araddr    <= 4'h0;
        rready    <= 1'b1;
        drv_lfsr = 16'd29847;
        chk_lfsr = 16'd29847;
        mismatch_errs = 0;
        timeout_errs  = 0;
        other_errs    = 0;
        msg_count     = 0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        if (out_valid !== 1'b0) begin
            $display("Mismatch at %0t: out_valid expected 0 got %b", $time, out_valid);
            mismatch_errs++;
        end
        if (in_ready !== 1'b1) begin
            $display("Mismatch at %0t: in_ready expected 1 got %b", $time, in_ready);
            mismatch_errs++;
        end

        fd = $fopen("testbench/b64_enc_golden.txt", "r");
        if (fd == 0) begin
            $display("Could not open the golden file");
            other_errs++;
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, " %c", tag);
                if (code != 1)
                    break;
                case (tag)
                    "#": code = $fgets(skip_line, fd);
                    "W": begin
                        code = $fscanf(fd, "%h %h", col_a, col_b);
                        write_reg(col_a[3:0], col_b);
                    end
                    "R": begin
                        code = $fscanf(fd, "%h %h", col_a, col_b);
                        read_check(col_a[3:0], col_b);
                    end
                    "B": begin
                        code = $fscanf(fd, "%h %h", col_a, col_b);
                        byte_q.push_back(col_a);
                        blast_q.push_back(col_b[0]);
                    end
                    "E": begin
                        code = $fscanf(fd, "%h %h", col_a, col_b);
                        exp_q.push_back(col_a);
                        elast_q.push_back(col_b[0]);
                    end
                    "M": begin
                        @(posedge clk);
                        fork
                            drive_bytes();
                            check_chars();
                        join
                        wait_idle();
                        msg_count++;
                        byte_q.delete();
                        blast_q.delete();
                        exp_q.delete();
                        elast_q.delete();
                    end
                    default: begin
                        $display("Unknown line tag '%c' in the golden file", tag);
                        other_errs++;
                    end
                endcase
            end
            $fclose(fd);
        end
        if (msg_count == 0) begin
            $display("The golden file held no complete message");
            other_errs++;
        end

        $display("Errors: %0d mismatch, %0d timeout, %0d other",
                 mismatch_errs, timeout_errs, other_errs);
        if (mismatch_errs + timeout_errs + other_errs == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

//--- logic/b64_enc_top.sv
// Streaming Base64 encoder top level
// Packer, sextet sequencer, alphabet map and AXI4-Lite register block

`timescale 1ns/100ps

module b64_enc_top #(
    parameter int CSR_ADDR_W = 4,
    parameter int COUNT_W    = 32
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // Input byte stream
    input  logic                             in_valid,
    output logic                             in_ready,
    input  logic [7:0]                       in_data,
    input  logic                             in_last,
    // Output character stream
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic [7:0]                       out_data,
    output logic                             out_last,
    // AXI4-Lite register port
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [CSR_ADDR_W-1:0]            awaddr,
    input  logic                             wvalid,
    output logic                             wready,
    input  logic [b64_pkg::AXIL_DATA_W-1:0]  wdata,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    input  logic                             arvalid,
    output logic                             arready,
    input  logic [CSR_ADDR_W-1:0]            araddr,
    output logic                             rvalid,
    input  logic                             rready,
    output logic [b64_pkg::AXIL_DATA_W-1:0]  rdata,
    output logic [1:0]                       rresp
);
    import b64_pkg::*;

    // Packer to sequencer
    logic       grp_valid;
    logic       grp_ready;
    b64_group_u grp_data;
    logic [1:0] grp_count;
    logic       grp_last;

    // Sequencer to mapper
    logic [5:0] sym_index;
    logic       sym_pad;
    logic [7:0] map_char;

    // Register block links
    logic       url_safe;
    logic       pad_en;
    logic       byte_accepted;
    logic       char_sent;
    logic       packer_pending;
    logic       seq_active;

    b64_csr #(
        .CSR_ADDR_W (CSR_ADDR_W),
        .COUNT_W    (COUNT_W)
    ) u_csr (
        .clk            (clk),
        .rst_n          (rst_n),
        .awvalid        (awvalid),
        .awready        (awready),
        .awaddr         (awaddr),
        .wvalid         (wvalid),
        .wready         (wready),
        .wdata          (wdata),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready),
        .arvalid        (arvalid),
        .arready        (arready),
        .araddr         (araddr),
        .rvalid         (rvalid),
        .rready         (rready),
        .rdata          (rdata),
        .rresp          (rresp),
        .byte_accepted  (byte_accepted),
        .char_sent      (char_sent),
        .packer_pending (packer_pending),
        .seq_active     (seq_active),
        .url_safe       (url_safe),
        .pad_en         (pad_en)
    );

    b64_group_packer u_packer (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .in_ready       (in_ready),
        .in_data        (in_data),
        .in_last        (in_last),
        .grp_valid      (grp_valid),
        .grp_ready      (grp_ready),
        .grp_data       (grp_data),
        .grp_count      (grp_count),
        .grp_last       (grp_last),
        .byte_accepted  (byte_accepted),
        .packer_pending (packer_pending)
    );

    b64_sextet_sequencer u_sequencer (
        .clk        (clk),
        .rst_n      (rst_n),
        .grp_valid  (grp_valid),
        .grp_ready  (grp_ready),
        .grp_data   (grp_data),
        .grp_count  (grp_count),
        .grp_last   (grp_last),
        .pad_en     (pad_en),
        .sym_index  (sym_index),
        .sym_pad    (sym_pad),
        .map_char   (map_char),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data),
        .out_last   (out_last),
        .char_sent  (char_sent),
        .seq_active (seq_active)
    );

    b64_alphabet_map u_map (
        .sym_index (sym_index),
        .sym_pad   (sym_pad),
        .url_safe  (url_safe),
        .map_char  (map_char)
    );

endmodule

//--- logic/b64_alphabet_map.sv
// Base64 alphabet map
// Sextet index or pad request to ASCII, standard or URL-safe alphabet

`timescale 1ns/100ps

module b64_alphabet_map (
    input  logic [5:0] sym_index,
    input  logic       sym_pad,
    input  logic       url_safe,
    output logic [7:0] map_char
);
    import b64_pkg::*;

    logic [7:0] idx;

    assign idx = {2'b00, sym_index};

    always_comb begin
        if (sym_pad) begin
            map_char = PAD_CHAR;
        end else if (idx < 8'd26) begin
            // 'A' .. 'Z'
            map_char = 8'h41 + idx;
        end else if (idx < 8'd52) begin
            // 'a' .. 'z' from index 26
            map_char = 8'h47 + idx;
        end else if (idx < 8'd62) begin
            // '0' .. '9' from index 52
            map_char = idx - 8'd4;
        end else if (idx == 8'd62) begin
            map_char = url_safe ? 8'h2D : 8'h2B;
        end else begin
            map_char = url_safe ? 8'h5F : 8'h2F;
        end
    end

endmodule

//--- logic/b64_sextet_sequencer.sv
// Base64 sextet sequencer
// Steps through each group's sextets, adds padding and drives the output stream

`timescale 1ns/100ps

module b64_sextet_sequencer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                grp_valid,
    output logic                grp_ready,
    input  b64_pkg::b64_group_u grp_data,
    input  logic [1:0]          grp_count,
    input  logic                grp_last,
    input  logic                pad_en,
    output logic [5:0]          sym_index,
    output logic                sym_pad,
    input  logic [7:0]          map_char,
    output logic                out_valid,
    input  logic                out_ready,
    output logic [7:0]          out_data,
    output logic                out_last,
    output logic                char_sent,
    output logic                seq_active
);
    import b64_pkg::*;

    b64_group_u cur;
    logic [1:0] cur_count;
    logic       cur_last;
    // Position of the character in the output register
    logic [1:0] pos;
    logic [1:0] last_pos;
    logic [1:0] next_pos;
    logic [1:0] load_last_pos;

    logic       at_end;
    logic       load;
    logic       step;

    assign char_sent     = out_valid && out_ready;
    assign at_end        = (pos == last_pos);
    assign next_pos      = pos + 2'd1;
    assign load_last_pos = pad_en ? 2'd3 : grp_count;

    // The next group is taken on the edge the final character leaves
    assign grp_ready  = !out_valid || (out_ready && at_end);
    assign load       = grp_valid && grp_ready;
    assign step       = out_valid && out_ready && !at_end;
    assign seq_active = out_valid;

    // Data characters are grp_count + 1, then pad
    always_comb begin
        if (load) begin
            sym_index = grp_data.sextets[3];
            sym_pad   = 1'b0;
        end else begin
            sym_index = cur.sextets[2'd3 - next_pos];
            sym_pad   = next_pos > cur_count;
        end
    end

    // ------------------------------------------------------------------
    // Position and output control
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos       <= 2'd0;
            last_pos  <= 2'd0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (load) begin
            pos       <= 2'd0;
            last_pos  <= load_last_pos;
            out_valid <= 1'b1;
            // A group always yields at least two characters
            out_last  <= 1'b0;
        end else if (step) begin
            pos      <= next_pos;
            out_last <= cur_last && (next_pos == last_pos);
        end else if (char_sent) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end
    end

    // Group and character payload
    always_ff @(posedge clk) begin
        if (load) begin
            cur       <= grp_data;
            cur_count <= grp_count;
            cur_last  <= grp_last;
        end
        if (load || step)
            out_data <= map_char;
    end

endmodule

//--- logic/b64_group_packer.sv
// Base64 group packer
// Collects input bytes into 24-bit groups and offers them to the sequencer

`timescale 1ns/100ps

module b64_group_packer (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    output logic                in_ready,
    input  logic [7:0]          in_data,
    input  logic                in_last,
    output logic                grp_valid,
    input  logic                grp_ready,
    output b64_pkg::b64_group_u grp_data,
    output logic [1:0]          grp_count,
    output logic                grp_last,
    output logic                byte_accepted,
    output logic                packer_pending
);
    import b64_pkg::*;

    // Collecting register
    b64_group_u col;
    b64_group_u col_next;
    logic [1:0] col_cnt;
    logic       col_full;
    logic       col_last;

    // Output slot
    b64_group_u slot;
    logic [1:0] slot_count;
    logic       slot_last;
    logic       slot_valid;

    logic       slot_free;
    logic       grp_done;

    // A finished group waiting in the collector blocks new bytes
    assign in_ready       = !col_full;
    assign byte_accepted  = in_valid && in_ready;
    assign slot_free      = !slot_valid || grp_ready;
    assign grp_done       = byte_accepted && (col_cnt == 2'd2 || in_last);
    assign packer_pending = (col_cnt != 2'd0) || slot_valid;

    assign grp_valid = slot_valid;
    assign grp_data  = slot;
    assign grp_count = slot_count;
    assign grp_last  = slot_last;

    // Incoming byte lands below the ones already collected
    always_comb begin
        col_next = col;
        col_next.bytes[2'd2 - col_cnt] = in_data;
    end

    // ------------------------------------------------------------------
    // Control and collector
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col        <= '0;
            col_cnt    <= 2'd0;
            col_full   <= 1'b0;
            col_last   <= 1'b0;
            slot_valid <= 1'b0;
        end else begin
            if (grp_valid && grp_ready)
                slot_valid <= 1'b0;

            if (col_full && slot_free) begin
                // Waiting group moves on, collector restarts zero filled
                slot_valid <= 1'b1;
                col        <= '0;
                col_cnt    <= 2'd0;
                col_full   <= 1'b0;
                col_last   <= 1'b0;
            end else if (byte_accepted) begin
                if (grp_done && slot_free) begin
                    slot_valid <= 1'b1;
                    col        <= '0;
                    col_cnt    <= 2'd0;
                end else begin
                    col      <= col_next;
                    col_cnt  <= col_cnt + 2'd1;
                    col_full <= grp_done;
                    col_last <= in_last;
                end
            end
        end
    end

    // Slot payload
    always_ff @(posedge clk) begin
        if (col_full && slot_free) begin
            slot       <= col;
            slot_count <= col_cnt;
            slot_last  <= col_last;
        end else if (grp_done && slot_free) begin
            slot       <= col_next;
            slot_count <= col_cnt + 2'd1;
            slot_last  <= in_last;
        end
    end

endmodule

//--- logic/b64_csr.sv
// Base64 encoder register block
// AXI4-Lite slave with control bits, byte and character counters, busy status

`timescale 1ns/100ps

module b64_csr #(
    parameter int CSR_ADDR_W = 4,
    parameter int COUNT_W    = 32
) (
    input  logic                             clk,
    input  logic                             rst_n,
    // AXI4-Lite write channels
    input  logic                             awvalid,
    output logic                             awready,
    input  logic [CSR_ADDR_W-1:0]            awaddr,
    input  logic                             wvalid,
    output logic                             wready,
    input  logic [b64_pkg::AXIL_DATA_W-1:0]  wdata,
    output logic [1:0]                       bresp,
    output logic                             bvalid,
    input  logic                             bready,
    // AXI4-Lite read channels
    input  logic                             arvalid,
    output logic                             arready,
    input  logic [CSR_ADDR_W-1:0]            araddr,
    output logic                             rvalid,
    input  logic                             rready,
    output logic [b64_pkg::AXIL_DATA_W-1:0]  rdata,
    output logic [1:0]                       rresp,
    // Datapath events
    input  logic                             byte_accepted,
    input  logic                             char_sent,
    input  logic                             packer_pending,
    input  logic                             seq_active,
    // Control outputs
    output logic                             url_safe,
    output logic                             pad_en
);
    import b64_pkg::*;

    logic               wr_en;
    logic               rd_en;
    logic               busy;
    logic [COUNT_W-1:0] byte_cnt;
    logic [COUNT_W-1:0] char_cnt;

    // Only the low four address bits select a register
    assign wr_en = awvalid && awready && wvalid && wready;
    assign rd_en = arvalid && arready;
    assign busy  = packer_pending | seq_active;

    // Every access answers OKAY
    assign bresp = 2'b00;
    assign rresp = 2'b00;

    // ------------------------------------------------------------------
    // Write path
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            awready  <= 1'b0;
            wready   <= 1'b0;
            bvalid   <= 1'b0;
            url_safe <= 1'b0;
            pad_en   <= 1'b1;
        end else begin
            // Address and data are taken together, one write at a time
            awready <= awvalid && wvalid && !awready && !bvalid;
            wready  <= awvalid && wvalid && !awready && !bvalid;

            if (wr_en) begin
                bvalid <= 1'b1;
                if (awaddr[3:0] == REG_CTRL) begin
                    url_safe <= wdata[CTRL_URL_SAFE];
                    pad_en   <= wdata[CTRL_PAD_EN];
                end
            end else if (bvalid && bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    // ------------------------------------------------------------------
    // Saturating counters, both cleared by a write to REG_BYTES
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            byte_cnt <= '0;
            char_cnt <= '0;
        end else if (wr_en && awaddr[3:0] == REG_BYTES) begin
            byte_cnt <= '0;
            char_cnt <= '0;
        end else begin
            if (byte_accepted && !(&byte_cnt))
                byte_cnt <= byte_cnt + 1'b1;
            if (char_sent && !(&char_cnt))
                char_cnt <= char_cnt + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            arready <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            arready <= arvalid && !arready && !rvalid;
            if (rd_en)
                rvalid <= 1'b1;
            else if (rvalid && rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            case (araddr[3:0])
                REG_CTRL: begin
                    rdata                <= '0;
                    rdata[CTRL_URL_SAFE] <= url_safe;
                    rdata[CTRL_PAD_EN]   <= pad_en;
                end
                REG_BYTES:  rdata <= AXIL_DATA_W'(byte_cnt);
                REG_CHARS:  rdata <= AXIL_DATA_W'(char_cnt);
                REG_STATUS: rdata <= AXIL_DATA_W'(busy);
                default:    rdata <= '0;
            endcase
        end
    end

endmodule

//--- logic/b64_pkg.sv
// Base64 encoder shared definitions
// Group views, register map and control bits

package b64_pkg;

    // One 24-bit group, read as bytes or as sextets
    // Element [2] / [3] holds the first byte / first character
    typedef union packed {
        logic [2:0][7:0] bytes;
        logic [3:0][5:0] sextets;
    } b64_group_u;

    // ------------------------------------------------------------------
    // Register port
    // ------------------------------------------------------------------
    localparam int AXIL_DATA_W = 32;

    localparam logic [3:0] REG_CTRL   = 4'h0;
    localparam logic [3:0] REG_BYTES  = 4'h4;
    localparam logic [3:0] REG_CHARS  = 4'h8;
    localparam logic [3:0] REG_STATUS = 4'hC;

    // Control register bits
    localparam int CTRL_URL_SAFE = 0;
    localparam int CTRL_PAD_EN   = 1;

    // ------------------------------------------------------------------
    // Output alphabet
    // ------------------------------------------------------------------
    localparam logic [7:0] PAD_CHAR = 8'h3D;

endpackage
